// File: tlb_entry_pkg.sv
package tlb_entry_pkg;

    // double-page tag, covers vaddr[31:13]
    localparam int vpn2_w = 19;
    localparam int pfn_w  = 20;
    localparam int asid_w = 8;

    // supported page sizes, as log2 of the byte count
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    // one half of an entry, even or odd page
    typedef struct packed {
        logic [pfn_w-1:0] pfn;
        logic [1:0]       mat;
        logic [1:0]       plv;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic [5:0]        ps;
        // entry exists
        logic              e;
        // global, ignores asid
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

endpackage

// File: tlb_access_pkg.sv
package tlb_access_pkg;

    // anything other than mapped translates as direct
    typedef enum logic [1:0] {
        mode_direct = 2'd0,
        mode_mapped = 2'd1
    } addr_mode_e;

    typedef enum logic [1:0] {
        mem_fetch = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_e;

    // at most one flag is set at a time
    typedef struct packed {
        // refill on miss
        logic tlbr;
        // page invalid, fetch / load / store
        logic pif;
        logic pil;
        logic pis;
        // page modify
        logic pme;
        // privilege
        logic ppi;
    } tlb_exc_t;

    // search request as held in the port register
    typedef struct packed {
        logic [31:0]                       vaddr;
        logic [tlb_entry_pkg::asid_w-1:0]  asid;
        logic [1:0]                        plv;
        mem_type_e                         mem_type;
        addr_mode_e                        mode;
    } tlb_req_t;

endpackage

// File: tlb_search_if.sv
interface tlb_search_if #(
    parameter int tlb_num = 16
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    // request side
    logic                       en;
    logic [31:0]                vaddr;
    logic [asid_w-1:0]          asid;
    logic [1:0]                 plv;
    mem_type_e                  mem_type;
    addr_mode_e                 mode;

    // result side, valid the cycle after en
    logic                       found;
    logic [$clog2(tlb_num)-1:0] index;
    logic [pfn_w-1:0]           pfn;
    logic [1:0]                 mat;
    logic [31:0]                paddr;
    tlb_exc_t                   exc;

    modport port (
        input  en, vaddr, asid, plv, mem_type, mode,
        output found, index, pfn, mat, paddr, exc
    );

    modport host (
        output en, vaddr, asid, plv, mem_type, mode,
        input  found, index, pfn, mat, paddr, exc
    );

endinterface

// File: tlb_memory.sv
module tlb_memory #(
    parameter int tlb_num = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       we,
    input  logic [$clog2(tlb_num)-1:0] w_index,
    input  tlb_entry_pkg::tlb_entry_t  w_entry,

    input  logic [$clog2(tlb_num)-1:0] r_index,
    output tlb_entry_pkg::tlb_entry_t  r_entry,

    output tlb_entry_pkg::tlb_entry_t  entries [tlb_num]
);
    import tlb_entry_pkg::*;

    // exists bit per entry, cleared on reset
    logic [tlb_num-1:0] e_q;
    tlb_entry_t         mem_q [tlb_num];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (we) begin
            e_q[w_index] <= w_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[w_index] <= w_entry;
        end
    end

    // all entries exposed for the search ports
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            entries[i]   = mem_q[i];
            entries[i].e = e_q[i];
        end
    end

    // read port for the management instructions, no latency
    assign r_entry = entries[r_index];

endmodule

// File: tlb_match.sv
module tlb_match #(
    parameter int tlb_num = 16
) (
    input  tlb_entry_pkg::tlb_entry_t         entries [tlb_num],
    input  logic [31:0]                       vaddr,
    input  logic [tlb_entry_pkg::asid_w-1:0]  asid,
    output logic                              found,
    output logic [$clog2(tlb_num)-1:0]        index,
    output tlb_entry_pkg::tlb_page_t          page,
    output logic [5:0]                        ps
);
    import tlb_entry_pkg::*;

    localparam int idx_w = $clog2(tlb_num);

    logic [tlb_num-1:0] hit;
    tlb_entry_t         sel;
    logic               odd;

    for (genvar i = 0; i < tlb_num; i++) begin : gen_hit
        logic tag_ok;
        logic asid_ok;

        // 2M pages only compare vaddr[31:22]
        assign tag_ok = (entries[i].ps == ps_2m) ?
                        (entries[i].vpn2[vpn2_w-1:9] == vaddr[31:22]) :
                        (entries[i].vpn2 == vaddr[31:13]);
        assign asid_ok = entries[i].g || (entries[i].asid == asid);
        assign hit[i]  = entries[i].e && asid_ok && tag_ok;
    end

    // scan downward so the lowest hit is taken last
    always_comb begin
        index = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit[i]) begin
                index = idx_w'(i);
            end
        end
    end

    assign found = |hit;
    assign sel   = entries[index];

    // odd page bit sits just above the page offset
    assign odd = (sel.ps == ps_2m) ? vaddr[21] : vaddr[12];

    always_comb begin
        if (!found) begin
            page = '0;
            ps   = '0;
        end else begin
            page = odd ? sel.page1 : sel.page0;
            ps   = sel.ps;
        end
    end

endmodule

// File: tlb_exc_check.sv
module tlb_exc_check (
    input  tlb_access_pkg::addr_mode_e mode,
    input  tlb_access_pkg::mem_type_e  mem_type,
    input  logic [1:0]                 plv,
    input  logic                       found,
    input  tlb_entry_pkg::tlb_page_t   page,
    output tlb_access_pkg::tlb_exc_t   exc
);
    import tlb_access_pkg::*;

    // first matching rule wins, direct mode never faults
    always_comb begin
        exc = '0;
        if (mode == mode_mapped) begin
            if (!found) begin
                exc.tlbr = 1'b1;
            end else if (!page.v) begin
                case (mem_type)
                    mem_fetch: exc.pif = 1'b1;
                    mem_store: exc.pis = 1'b1;
                    default:   exc.pil = 1'b1;
                endcase
            end else if (plv > page.plv) begin
                // larger plv is less privileged
                exc.ppi = 1'b1;
            end else if ((mem_type == mem_store) && !page.d) begin
                exc.pme = 1'b1;
            end
        end
    end

endmodule

// File: tlb_search_port.sv
module tlb_search_port #(
    parameter int tlb_num = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    tlb_search_if.port                sp,
    input  tlb_entry_pkg::tlb_entry_t entries [tlb_num]
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    tlb_req_t                   req_q;
    logic                       found;
    logic [$clog2(tlb_num)-1:0] index;
    tlb_page_t                  page;
    logic [5:0]                 ps;
    tlb_exc_t                   exc;
    logic [31:0]                paddr;

    // cleared request reads as direct mode at vaddr 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (sp.en) begin
            req_q <= '{vaddr: sp.vaddr, asid: sp.asid, plv: sp.plv,
                       mem_type: sp.mem_type, mode: sp.mode};
        end
    end

    tlb_match #(
        .tlb_num (tlb_num)
    ) match (
        .entries (entries),
        .vaddr   (req_q.vaddr),
        .asid    (req_q.asid),
        .found   (found),
        .index   (index),
        .page    (page),
        .ps      (ps)
    );

    tlb_exc_check exc_check (
        .mode     (req_q.mode),
        .mem_type (req_q.mem_type),
        .plv      (req_q.plv),
        .found    (found),
        .page     (page),
        .exc      (exc)
    );

    always_comb begin
        if (req_q.mode != mode_mapped) begin
            paddr = req_q.vaddr;
        end else if (!found) begin
            paddr = '0;
        end else if (ps == ps_2m) begin
            paddr = {page.pfn[pfn_w-1:9], req_q.vaddr[20:0]};
        end else begin
            paddr = {page.pfn, req_q.vaddr[11:0]};
        end
    end

    assign sp.found = found;
    assign sp.index = index;
    assign sp.pfn   = page.pfn;
    assign sp.mat   = page.mat;
    assign sp.paddr = paddr;
    assign sp.exc   = exc;

endmodule

// File: tlb.sv
module tlb #(
    parameter int tlb_num = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 ad_mode,

    // search port 0, instruction fetch
    input  logic [31:0]                s0_vaddr,
    input  logic [7:0]                 s0_asid,
    input  logic [1:0]                 s0_plv,
    input  logic [1:0]                 s0_mem_type,
    input  logic                       s0_en,
    output logic                       s0_found,
    output logic [$clog2(tlb_num)-1:0] s0_index,
    output logic [19:0]                s0_pfn,
    output logic [1:0]                 s0_mat,
    output logic [31:0]                s0_paddr,
    output logic [5:0]                 s0_exception,

    // search port 1, data
    input  logic [31:0]                s1_vaddr,
    input  logic [7:0]                 s1_asid,
    input  logic [1:0]                 s1_plv,
    input  logic [1:0]                 s1_mem_type,
    input  logic                       s1_en,
    output logic                       s1_found,
    output logic [$clog2(tlb_num)-1:0] s1_index,
    output logic [19:0]                s1_pfn,
    output logic [1:0]                 s1_mat,
    output logic [31:0]                s1_paddr,
    output logic [5:0]                 s1_exception,

    // write port
    input  logic                       we,
    input  logic [$clog2(tlb_num)-1:0] w_index,
    input  logic [18:0]                w_vpn2,
    input  logic [7:0]                 w_asid,
    input  logic [5:0]                 w_ps,
    input  logic                       w_e,
    input  logic                       w_g,
    input  logic [19:0]                w_pfn0,
    input  logic [1:0]                 w_mat0,
    input  logic [1:0]                 w_plv0,
    input  logic                       w_d0,
    input  logic                       w_v0,
    input  logic [19:0]                w_pfn1,
    input  logic [1:0]                 w_mat1,
    input  logic [1:0]                 w_plv1,
    input  logic                       w_d1,
    input  logic                       w_v1,

    // read port
    input  logic [$clog2(tlb_num)-1:0] r_index,
    output logic [18:0]                r_vpn2,
    output logic [7:0]                 r_asid,
    output logic [5:0]                 r_ps,
    output logic                       r_e,
    output logic                       r_g,
    output logic [19:0]                r_pfn0,
    output logic [1:0]                 r_mat0,
    output logic [1:0]                 r_plv0,
    output logic                       r_d0,
    output logic                       r_v0,
    output logic [19:0]                r_pfn1,
    output logic [1:0]                 r_mat1,
    output logic [1:0]                 r_plv1,
    output logic                       r_d1,
    output logic                       r_v1
);
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    tlb_entry_t w_entry;
    tlb_entry_t r_entry;
    tlb_entry_t entries [tlb_num];

    tlb_search_if #(.tlb_num(tlb_num)) s0_if ();
    tlb_search_if #(.tlb_num(tlb_num)) s1_if ();

    // port 0 request, mode is shared
    assign s0_if.en       = s0_en;
    assign s0_if.vaddr    = s0_vaddr;
    assign s0_if.asid     = s0_asid;
    assign s0_if.plv      = s0_plv;
    assign s0_if.mem_type = mem_type_e'(s0_mem_type);
    assign s0_if.mode     = addr_mode_e'(ad_mode);

    assign s0_found     = s0_if.found;
    assign s0_index     = s0_if.index;
    assign s0_pfn       = s0_if.pfn;
    assign s0_mat       = s0_if.mat;
    assign s0_paddr     = s0_if.paddr;
    assign s0_exception = s0_if.exc;

    assign s1_if.en       = s1_en;
    assign s1_if.vaddr    = s1_vaddr;
    assign s1_if.asid     = s1_asid;
    assign s1_if.plv      = s1_plv;
    assign s1_if.mem_type = mem_type_e'(s1_mem_type);
    assign s1_if.mode     = addr_mode_e'(ad_mode);

    assign s1_found     = s1_if.found;
    assign s1_index     = s1_if.index;
    assign s1_pfn       = s1_if.pfn;
    assign s1_mat       = s1_if.mat;
    assign s1_paddr     = s1_if.paddr;
    assign s1_exception = s1_if.exc;

    assign w_entry = '{
        vpn2:  w_vpn2,
        asid:  w_asid,
        ps:    w_ps,
        e:     w_e,
        g:     w_g,
        page0: '{pfn: w_pfn0, mat: w_mat0, plv: w_plv0, d: w_d0, v: w_v0},
        page1: '{pfn: w_pfn1, mat: w_mat1, plv: w_plv1, d: w_d1, v: w_v1}
    };

    assign r_vpn2 = r_entry.vpn2;
    assign r_asid = r_entry.asid;
    assign r_ps   = r_entry.ps;
    assign r_e    = r_entry.e;
    assign r_g    = r_entry.g;
    assign r_pfn0 = r_entry.page0.pfn;
    assign r_mat0 = r_entry.page0.mat;
    assign r_plv0 = r_entry.page0.plv;
    assign r_d0   = r_entry.page0.d;
    assign r_v0   = r_entry.page0.v;
    assign r_pfn1 = r_entry.page1.pfn;
    assign r_mat1 = r_entry.page1.mat;
    assign r_plv1 = r_entry.page1.plv;
    assign r_d1   = r_entry.page1.d;
    assign r_v1   = r_entry.page1.v;

    tlb_memory #(
        .tlb_num (tlb_num)
    ) memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    tlb_search_port #(
        .tlb_num (tlb_num)
    ) port0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .sp      (s0_if.port),
        .entries (entries)
    );

    tlb_search_port #(
        .tlb_num (tlb_num)
    ) port1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .sp      (s1_if.port),
        .entries (entries)
    );

endmodule

// File: tlb_assertions.sv
module tlb_assertions #(
    parameter int tlb_num = 16
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic [1:0]                 ad_mode,
    input logic                       s0_en,
    input logic                       s1_en,
    input logic                       s0_found,
    input logic                       s1_found,
    input logic [$clog2(tlb_num)-1:0] s0_index,
    input logic [$clog2(tlb_num)-1:0] s1_index,
    input logic [5:0]                 s0_exception,
    input logic [5:0]                 s1_exception
);
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_access_pkg::*;

    logic [1:0] s0_mode_q;
    logic [1:0] s1_mode_q;
    int         fail_count = 0;

    // mode as captured along with each port's request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_mode_q <= '0;
            s1_mode_q <= '0;
        end else begin
            if (s0_en) begin
                s0_mode_q <= ad_mode;
            end
            if (s1_en) begin
                s1_mode_q <= ad_mode;
            end
        end
    end

    s0_exc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s0_exception)) else begin
        fail_count++;
        $error("port 0 raised several exception flags");
    end
    s1_exc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s1_exception)) else begin
        fail_count++;
        $error("port 1 raised several exception flags");
    end

    s0_direct_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (s0_mode_q != mode_mapped) |-> (s0_exception == '0)) else begin
        fail_count++;
        $error("port 0 raised an exception in direct mode");
    end
    s1_direct_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_mode_q != mode_mapped) |-> (s1_exception == '0)) else begin
        fail_count++;
        $error("port 1 raised an exception in direct mode");
    end

    // a hit never comes with a refill flag
    s0_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        s0_found |-> (s0_index < tlb_num) && !s0_exception[5]) else begin
        fail_count++;
        $error("port 0 hit with a bad index or a refill flag");
    end
    s1_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        s1_found |-> (s1_index < tlb_num) && !s1_exception[5]) else begin
        fail_count++;
        $error("port 1 hit with a bad index or a refill flag");
    end

endmodule

// File: tlb_tb.sv
module tlb_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_entry_pkg::*;
    import tlb_access_pkg::*;

    localparam int tlb_num = 16;
    localparam int idx_w   = $clog2(tlb_num);
    // tests take about 75 cycles
    localparam int timeout_cycles = 600;

    typedef struct packed {
        logic             found;
        logic [idx_w-1:0] index;
        logic [pfn_w-1:0] pfn;
        logic [1:0]       mat;
        logic [31:0]      paddr;
        tlb_exc_t         exc;
    } result_t;

    logic             clk;
    logic             rst_n;
    logic [1:0]       ad_mode;
    logic             s0_en, s1_en, s0_found, s1_found;
    logic [31:0]      s0_vaddr, s1_vaddr, s0_paddr, s1_paddr;
    logic [7:0]       s0_asid, s1_asid;
    logic [1:0]       s0_plv, s1_plv, s0_mem_type, s1_mem_type, s0_mat, s1_mat;
    logic [idx_w-1:0] s0_index, s1_index, w_index, r_index;
    logic [19:0]      s0_pfn, s1_pfn, w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    logic [5:0]       s0_exception, s1_exception, w_ps, r_ps;
    logic             we, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic             r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    logic [18:0]      w_vpn2, r_vpn2;
    logic [7:0]       w_asid, r_asid;
    logic [1:0]       w_mat0, w_plv0, w_mat1, w_plv1, r_mat0, r_plv0, r_mat1, r_plv1;

    tlb_entry_t r_got;
    result_t    got0;
    result_t    got1;
    tlb_entry_t ref_mem [tlb_num];
    tlb_req_t   last_req [2];
    integer     seed = 52;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;

    tlb #(.tlb_num(tlb_num)) tlb_inst (.*);

    bind tlb tlb_assertions #(.tlb_num(tlb_num)) assertions_inst (.*);

    assign r_got = {r_vpn2, r_asid, r_ps, r_e, r_g, r_pfn0, r_mat0, r_plv0, r_d0, r_v0,
                    r_pfn1, r_mat1, r_plv1, r_d1, r_v1};
    assign got0  = {s0_found, s0_index, s0_pfn, s0_mat, s0_paddr, s0_exception};
    assign got1  = {s1_found, s1_index, s1_pfn, s1_mat, s1_paddr, s1_exception};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string name, input string got, input string exp);
        errors++;
        $display("Error at %0t ns: %s = %s, expected %s", $time, name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_index(input string name, input logic [idx_w-1:0] got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_pfn(input string name, input logic [pfn_w-1:0] got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_mat(input string name, input logic [1:0] got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_paddr(input string name, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_exc(input string name, input tlb_exc_t got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got, exp);
        checks++;
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    function automatic tlb_page_t make_page(input logic [19:0] pfn, input logic [1:0] mat,
                                            input logic [1:0] plv, input logic d, v);
        return '{pfn: pfn, mat: mat, plv: plv, d: d, v: v};
    endfunction

    function automatic tlb_entry_t make_entry(input logic [18:0] vpn2, input logic [7:0] asid,
                                              input logic [5:0] ps, input logic g,
                                              input tlb_page_t p0, p1);
        return '{vpn2: vpn2, asid: asid, ps: ps, e: 1'b1, g: g, page0: p0, page1: p1};
    endfunction

    function automatic tlb_req_t make_req(input logic [31:0] vaddr, input logic [7:0] asid,
                                          input logic [1:0] plv, input mem_type_e mt,
                                          input addr_mode_e mode);
        return '{vaddr: vaddr, asid: asid, plv: plv, mem_type: mt, mode: mode};
    endfunction

    // reference translation over the written entries
    function automatic result_t expect_result(input tlb_req_t req);
        result_t   r;
        tlb_page_t pg;
        logic      big;
        logic      hit;
        r  = '0;
        pg = '0;
        for (int i = 0; i < tlb_num; i++) begin
            big = (ref_mem[i].ps == ps_2m);
            hit = ref_mem[i].e && (ref_mem[i].g || ref_mem[i].asid == req.asid) &&
                  (big ? (ref_mem[i].vpn2[18:9] == req.vaddr[31:22])
                       : (ref_mem[i].vpn2 == req.vaddr[31:13]));
            if (hit && !r.found) begin
                r.found = 1'b1;
                r.index = idx_w'(i);
                pg      = (big ? req.vaddr[21] : req.vaddr[12]) ? ref_mem[i].page1
                                                                : ref_mem[i].page0;
                r.pfn   = pg.pfn;
                r.mat   = pg.mat;
                r.paddr = big ? {pg.pfn[19:9], req.vaddr[20:0]} : {pg.pfn, req.vaddr[11:0]};
            end
        end
        if (req.mode != mode_mapped) begin
            r.paddr = req.vaddr;
        end else if (!r.found) begin
            r.exc.tlbr = 1'b1;
        end else if (!pg.v) begin
            if (req.mem_type == mem_fetch) r.exc.pif = 1'b1;
            else if (req.mem_type == mem_store) r.exc.pis = 1'b1;
            else r.exc.pil = 1'b1;
        end else if (req.plv > pg.plv) begin
            r.exc.ppi = 1'b1;
        end else if (req.mem_type == mem_store && !pg.d) begin
            r.exc.pme = 1'b1;
        end
        return r;
    endfunction

    task automatic verify_port(input int p, input tlb_req_t req);
        result_t exp;
        result_t got;
        string   pre;
        exp = expect_result(req);
        got = (p == 0) ? got0 : got1;
        pre = $sformatf("s%0d_", p);
        check_paddr({pre, "paddr"}, got.paddr, exp.paddr);
        check_exc({pre, "exception"}, got.exc, exp.exc);
        if (req.mode == mode_mapped) begin
            check_bit({pre, "found"}, got.found, exp.found);
            if (exp.found) begin
                check_index({pre, "index"}, got.index, exp.index);
                check_pfn({pre, "pfn"}, got.pfn, exp.pfn);
                check_mat({pre, "mat"}, got.mat, exp.mat);
            end
        end
    endtask

    task automatic write_entry(input logic [idx_w-1:0] idx, input tlb_entry_t ent);
        we      = 1'b1;
        w_index = idx;
        {w_vpn2, w_asid, w_ps, w_e, w_g, w_pfn0, w_mat0, w_plv0, w_d0, w_v0,
         w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = ent;
        next_slot();
        we           = 1'b0;
        ref_mem[idx] = ent;
    endtask

    // one request cycle on either or both ports, mode shared
    task automatic search(input logic en0, input tlb_req_t q0,
                          input logic en1, input tlb_req_t q1);
        s0_en = en0;
        s1_en = en1;
        {s0_vaddr, s0_asid, s0_plv, s0_mem_type} = {q0.vaddr, q0.asid, q0.plv, q0.mem_type};
        {s1_vaddr, s1_asid, s1_plv, s1_mem_type} = {q1.vaddr, q1.asid, q1.plv, q1.mem_type};
        ad_mode = en0 ? q0.mode : q1.mode;
        next_slot();
        s0_en = 1'b0;
        s1_en = 1'b0;
        if (en0) last_req[0] = q0;
        if (en1) last_req[1] = q1;
        if (en0) verify_port(0, q0);
        if (en1) verify_port(1, q1);
    endtask

    task automatic test_readback();
        logic [95:0] rnd;
        for (int i = 0; i < tlb_num; i++) begin
            rnd = {$random(seed), $random(seed), $random(seed)};
            write_entry(idx_w'(i), rnd[$bits(tlb_entry_t)-1:0]);
        end
        for (int i = 0; i < tlb_num; i++) begin
            r_index = idx_w'(i);
            @(negedge clk);
            check_entry($sformatf("r_entry[%0d]", i), r_got, ref_mem[i]);
            next_slot();
        end
        for (int i = 0; i < tlb_num; i++) begin
            write_entry(idx_w'(i), '0);
        end
    endtask

    task automatic test_mapped_4k();
        write_entry(2, make_entry(19'h12345, 8'h11, ps_4k, 1'b0,
                    make_page(20'habcde, 2'd1, 2'd0, 1'b1, 1'b1),
                    make_page(20'h54321, 2'd2, 2'd0, 1'b1, 1'b1)));
        write_entry(5, make_entry(19'h0f0f0, 8'h22, ps_4k, 1'b1,
                    make_page(20'h11111, 2'd0, 2'd3, 1'b1, 1'b1),
                    make_page(20'h22222, 2'd3, 2'd3, 1'b1, 1'b1)));
        search(1'b1, make_req({19'h12345, 1'b0, 12'h123}, 8'h11, 2'd0, mem_fetch, mode_mapped),
               1'b1, make_req({19'h12345, 1'b1, 12'hffc}, 8'h11, 2'd0, mem_load, mode_mapped));
        check_index("s0_index", s0_index, 2);
        // global entry hits under foreign asids
        search(1'b1, make_req({19'h0f0f0, 1'b1, 12'h004}, 8'h99, 2'd3, mem_fetch, mode_mapped),
               1'b1, make_req({19'h0f0f0, 1'b0, 12'h800}, 8'h77, 2'd1, mem_store, mode_mapped));
        check_bit("s0_found", s0_found, 1'b1);
    endtask

    task automatic test_miss();
        search(1'b1, make_req(32'h7654_3210, 8'h11, 2'd0, mem_load, mode_mapped),
               1'b1, make_req({19'h12345, 1'b0, 12'h000}, 8'h33, 2'd0, mem_load, mode_mapped));
        check_exc("s1_exception", s1_exception, 6'b10_0000);
        write_entry(9, make_entry(19'h70000, 8'h01, ps_4k, 1'b1,
                    make_page(20'h99999, 2'd1, 2'd0, 1'b1, 1'b1),
                    make_page(20'h99998, 2'd1, 2'd0, 1'b1, 1'b1)));
        write_entry(4, make_entry(19'h70000, 8'h01, ps_4k, 1'b1,
                    make_page(20'h44444, 2'd2, 2'd0, 1'b1, 1'b1),
                    make_page(20'h44445, 2'd2, 2'd0, 1'b1, 1'b1)));
        search(1'b1, make_req({19'h70000, 13'h0040}, 8'h01, 2'd0, mem_load, mode_mapped),
               1'b0, '0);
        check_index("s0_index", s0_index, 4);
    endtask

    task automatic test_2m();
        write_entry(7, make_entry({10'h2a5, 9'h1a3}, 8'h05, ps_2m, 1'b1,
                    make_page(20'h12a00, 2'd1, 2'd0, 1'b1, 1'b1),
                    make_page(20'h34c5f, 2'd2, 2'd0, 1'b1, 1'b1)));
        search(1'b1, make_req({10'h2a5, 1'b0, 21'h00_2345}, 8'h05, 2'd0, mem_load, mode_mapped),
               1'b1, make_req({10'h2a5, 1'b0, 21'h1f_e001}, 8'h05, 2'd0, mem_load, mode_mapped));
        check_index("s1_index", s1_index, 7);
        search(1'b1, make_req({10'h2a5, 1'b1, 21'h00_0abc}, 8'h05, 2'd0, mem_load, mode_mapped),
               1'b0, '0);
        check_pfn("s0_pfn", s0_pfn, 20'h34c5f);
    endtask

    task automatic test_exceptions();
        logic [31:0] even;
        logic [31:0] odd;
        even = {19'h40000, 1'b0, 12'h010};
        odd  = {19'h40000, 1'b1, 12'h020};
        // even half invalid, odd half valid but clean
        write_entry(10, make_entry(19'h40000, 8'h00, ps_4k, 1'b1,
                    make_page(20'h0aaaa, 2'd1, 2'd0, 1'b1, 1'b0),
                    make_page(20'h0bbbb, 2'd1, 2'd0, 1'b0, 1'b1)));
        search(1'b1, make_req(even, 8'h00, 2'd0, mem_fetch, mode_mapped),
               1'b1, make_req(even, 8'h00, 2'd0, mem_load, mode_mapped));
        search(1'b1, make_req(even, 8'h00, 2'd0, mem_store, mode_mapped),
               1'b1, make_req(odd, 8'h00, 2'd3, mem_load, mode_mapped));
        check_exc("s1_exception", s1_exception, 6'b00_0001);
        search(1'b1, make_req(odd, 8'h00, 2'd0, mem_store, mode_mapped),
               1'b1, make_req(odd, 8'h00, 2'd0, mem_load, mode_mapped));
        check_exc("s0_exception", s0_exception, 6'b00_0010);
        // invalid outranks privilege
        search(1'b1, make_req({19'h12345, 1'b0, 12'h0}, 8'h11, 2'd0, mem_store, mode_mapped),
               1'b1, make_req(even, 8'h00, 2'd3, mem_load, mode_mapped));
    endtask

    task automatic test_direct();
        search(1'b1, make_req({19'h12345, 1'b0, 12'h123}, 8'h11, 2'd0, mem_store, mode_direct),
               1'b1, make_req(32'hdead_beef, 8'h00, 2'd3, mem_load, mode_direct));
        check_paddr("s1_paddr", s1_paddr, 32'hdead_beef);
        search(1'b1, make_req({19'h40000, 1'b0, 12'h010}, 8'h00, 2'd3, mem_fetch,
                              addr_mode_e'(2'd3)),
               1'b1, make_req(32'h1234_5678, 8'h00, 2'd3, mem_store, addr_mode_e'(2'd3)));
        search(1'b1, make_req({19'h12345, 1'b1, 12'h040}, 8'h11, 2'd0, mem_load, mode_mapped),
               1'b0, '0);
        // new odd frame for entry 2 while the request is held
        write_entry(2, make_entry(19'h12345, 8'h11, ps_4k, 1'b0,
                    make_page(20'habcde, 2'd1, 2'd0, 1'b1, 1'b1),
                    make_page(20'h0f00d, 2'd1, 2'd0, 1'b1, 1'b1)));
        verify_port(0, last_req[0]);
        check_pfn("s0_pfn", s0_pfn, 20'h0f00d);
    endtask

    initial begin
        rst_n   = 1'b0;
        ad_mode = 2'd0;
        s0_en   = 1'b0;
        s1_en   = 1'b0;
        we      = 1'b0;
        r_index = '0;
        w_index = '0;
        {s0_vaddr, s0_asid, s0_plv, s0_mem_type} = '0;
        {s1_vaddr, s1_asid, s1_plv, s1_mem_type} = '0;
        {w_vpn2, w_asid, w_ps, w_e, w_g, w_pfn0, w_mat0, w_plv0, w_d0, w_v0,
         w_pfn1, w_mat1, w_plv1, w_d1, w_v1} = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("s0_found", s0_found, 1'b0);
        check_paddr("s1_paddr", s1_paddr, '0);
        check_exc("s0_exception", s0_exception, '0);
        test_readback();
        test_mapped_4k();
        test_miss();
        test_2m();
        test_exceptions();
        test_direct();
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 tlb_inst.assertions_inst.fail_count);
        if (errors == 0 && tlb_inst.assertions_inst.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
tlb_entry_pkg.sv
tlb_access_pkg.sv
tlb_search_if.sv
tlb_memory.sv
tlb_match.sv
tlb_exc_check.sv
tlb_search_port.sv
tlb.sv
tlb_assertions.sv
tlb_tb.sv

// File: Bender.yml
package:
  name: tlb

sources:
  - tlb_entry_pkg.sv
  - tlb_access_pkg.sv
  - tlb_search_if.sv
  - tlb_memory.sv
  - tlb_match.sv
  - tlb_exc_check.sv
  - tlb_search_port.sv
  - tlb.sv
  - target: test
    files:
      - tlb_assertions.sv
      - tlb_tb.sv
